// ==== src/pcxt_ctrl_pkg.sv ====
// PC/XT system control definitions
package pcxt_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Menu status word
	////////////////////////////////////////////////////////////

	typedef logic [31:0] status_word_t;

	// Bit positions in the status word
	localparam int STATUS_RESET_BIT       = 0;
	// Two bits wide
	localparam int STATUS_SCALE_LSB       = 1;
	localparam int STATUS_TANDY_BIT       = 3;
	localparam int STATUS_MDA_BIT         = 4;
	localparam int STATUS_SPLASH_SKIP_BIT = 7;
	// Two bits wide
	localparam int STATUS_AR_LSB          = 8;

	////////////////////////////////////////////////////////////
	// Rates and counts
	////////////////////////////////////////////////////////////

	// System clock
	localparam int CLK_HZ               = 50_000_000;
	// Audio sample rate
	localparam int SAMPLE_HZ            = 44_100;
	localparam int RATE_ACC_W           = 32;
	// Stretch of 2^16 cycles
	localparam int RESET_STRETCH_W      = 16;
	localparam int CPU_RESET_DELAY      = 42;
	localparam int SPLASH_SECONDS       = 5;
	// One splash second in clock cycles
	localparam int SPLASH_TICKS_DEFAULT = CLK_HZ;

	// PC/XT DIP switch words
	localparam logic [7:0] DIP_SW_CGA = 8'h2D;
	localparam logic [7:0] DIP_SW_MDA = 8'h3D;

	// Original 4:3 display
	localparam int AR_DEFAULT_X = 4;
	localparam int AR_DEFAULT_Y = 3;

	////////////////////////////////////////////////////////////
	// Packed bundles
	////////////////////////////////////////////////////////////

	// Top bit flags a scaled size
	typedef logic [12:0] ar_dim_t;

	typedef struct packed {
		logic clk;
		logic data;
	} ps2_lines_t;

	typedef struct packed {
		ar_dim_t    arx;
		ar_dim_t    ary;
		logic [1:0] vga_sl;
		logic       scandoubler;
		logic       hq2x;
		logic       mda_mode;
		logic       tandy_mode;
	} video_cfg_t;

	// One-cycle enables
	typedef struct packed {
		logic cen_44100;
		logic cen_opl2;
	} audio_en_t;

endpackage

// ==== src/input_sync.sv ====
// Two flop input synchronizer
`timescale 1ns/10ps

module input_sync #(
	parameter type T = logic
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  T     d,
	output T     q
);

	// First stage may go metastable
	T meta;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			meta <= '0;
			q    <= '0;
		end else begin
			meta <= d;
			q    <= meta;
		end
	end

endmodule

// ==== src/splash_timer.sv ====
// Splash screen hold timer
`timescale 1ns/10ps

module splash_timer
	import pcxt_ctrl_pkg::*;
#(
	parameter int SPLASH_TICKS = SPLASH_TICKS_DEFAULT
) (
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic skip,
	output logic splash_active
);

	// Counter widths
	localparam int TICK_W = $clog2(SPLASH_TICKS + 1);
	localparam int SEC_W  = $clog2(SPLASH_SECONDS + 1);

	// Cycles within the current second
	logic [TICK_W-1:0] tick_cnt;
	// Whole seconds elapsed
	logic [SEC_W-1:0]  sec_cnt;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			// Skip ends the splash on the first edge
			if (skip || sec_cnt == SEC_W'(SPLASH_SECONDS)) begin
				splash_active <= 1'b0;
			end else if (tick_cnt == TICK_W'(SPLASH_TICKS - 1)) begin
				// End of one splash second
				tick_cnt <= '0;
				sec_cnt  <= sec_cnt + 1'b1;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
		// Holds cleared until the next reset
	end

endmodule

// ==== src/reset_stretcher.sv ====
// System reset stretcher
`timescale 1ns/10ps

module reset_stretcher
	import pcxt_ctrl_pkg::*;
(
	input  logic CLK_50M,
	input  logic reset_wire,
	input  logic splash_active,
	input  logic host_reset,
	input  logic user_button,
	output logic sys_reset
);

	// Sampled reset sources
	logic reset_req;
	// Cycles without any request
	logic [RESET_STRETCH_W-1:0] stretch_cnt;

	// Merged synchronous requests
	assign reset_req = splash_active | host_reset | user_button;

	////////////////////////////////////////////////////////////
	// Stretch counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset   <= 1'b1;
			stretch_cnt <= '0;
		end else if (reset_req) begin
			// Restart the hold on any request
			sys_reset   <= 1'b1;
			stretch_cnt <= '0;
		end else if (sys_reset) begin
			if (&stretch_cnt) begin
				// Full count reached
				sys_reset <= 1'b0;
			end else begin
				stretch_cnt <= stretch_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== src/cpu_reset_delay.sv ====
// CPU reset release delay
`timescale 1ns/10ps

module cpu_reset_delay
	import pcxt_ctrl_pkg::*;
(
	input  logic CLK_50M,
	input  logic sys_reset,
	output logic cpu_reset
);

	localparam int CNT_W = $clog2(CPU_RESET_DELAY + 1);

	// Registered copy of the system reset
	logic             sys_reset_q;
	// Cycles left until release
	logic [CNT_W-1:0] delay_cnt;

	// System reset doubles as the async reset here
	always_ff @(posedge CLK_50M or posedge sys_reset) begin
		if (sys_reset) begin
			sys_reset_q <= 1'b1;
			delay_cnt   <= CNT_W'(CPU_RESET_DELAY);
			cpu_reset   <= 1'b1;
		end else begin
			sys_reset_q <= sys_reset;
			// Count only once the follower has dropped
			if (!sys_reset_q && delay_cnt != '0) begin
				delay_cnt <= delay_cnt - 1'b1;
				// Release as the count hits zero
				cpu_reset <= (delay_cnt != CNT_W'(1));
			end
		end
	end

endmodule

// ==== src/audio_enables.sv ====
// Audio clock enables
`timescale 1ns/10ps

module audio_enables
	import pcxt_ctrl_pkg::*;
(
	input  logic      CLK_50M,
	input  logic      reset_wire,
	input  logic      opl2_clk,
	output audio_en_t audio_en
);

	////////////////////////////////////////////////////////////
	// 44.1 kHz fractional accumulator
	////////////////////////////////////////////////////////////

	logic [RATE_ACC_W-1:0] rate_acc;
	logic [RATE_ACC_W-1:0] rate_acc_next;

	assign rate_acc_next = rate_acc + RATE_ACC_W'(SAMPLE_HZ);

	////////////////////////////////////////////////////////////
	// FM clock edge detect
	////////////////////////////////////////////////////////////

	// FM clock after the sync chain
	logic opl2_sync;
	// Previous synced level
	logic opl2_prev;

	input_sync #(
		.T(logic)
	) u_opl2_sync (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.d          (opl2_clk),
		.q          (opl2_sync)
	);

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			rate_acc  <= '0;
			opl2_prev <= 1'b0;
			audio_en  <= '0;
		end else begin
			opl2_prev         <= opl2_sync;
			// Rising edge of the FM clock
			audio_en.cen_opl2 <= opl2_sync & ~opl2_prev;
			if (rate_acc_next >= RATE_ACC_W'(CLK_HZ)) begin
				// Wrap and keep the remainder
				rate_acc           <= rate_acc_next - RATE_ACC_W'(CLK_HZ);
				audio_en.cen_44100 <= 1'b1;
			end else begin
				rate_acc           <= rate_acc_next;
				audio_en.cen_44100 <= 1'b0;
			end
		end
	end

endmodule

// ==== src/config_decode.sv ====
// Status word configuration decoder
`timescale 1ns/10ps

module config_decode
	import pcxt_ctrl_pkg::*;
(
	input  status_word_t status,
	input  logic [7:0]   port_b_out,
	output video_cfg_t   video_cfg,
	output logic [3:0]   port_c_low
);

	// Menu fields
	logic [1:0] ar;
	logic [1:0] scale;
	// Active DIP switch word
	logic [7:0] dip_sw;

	assign ar    = status[STATUS_AR_LSB +: 2];
	assign scale = status[STATUS_SCALE_LSB +: 2];

	////////////////////////////////////////////////////////////
	// Video configuration
	////////////////////////////////////////////////////////////

	always_comb begin
		video_cfg.mda_mode   = status[STATUS_MDA_BIT];
		video_cfg.tandy_mode = status[STATUS_TANDY_BIT];

		// Aspect ratio
		if (ar == 2'd0) begin
			video_cfg.arx = ar_dim_t'(AR_DEFAULT_X);
			video_cfg.ary = ar_dim_t'(AR_DEFAULT_Y);
		end else begin
			// Custom ratio codes 0 to 2
			video_cfg.arx = ar_dim_t'(ar - 2'd1);
			video_cfg.ary = '0;
		end

		// Scanline mask
		video_cfg.vga_sl      = {scale == 2'd3, scale == 2'd2};
		// Any filter needs the scandoubler
		video_cfg.scandoubler = (scale != 2'd0);
		video_cfg.hq2x        = (scale == 2'd1);
	end

	////////////////////////////////////////////////////////////
	// PPI switch readback
	////////////////////////////////////////////////////////////

	// MDA or CGA 80 column switches
	assign dip_sw = status[STATUS_MDA_BIT] ? DIP_SW_MDA : DIP_SW_CGA;

	// Port B bit 3 selects the upper nibble
	assign port_c_low = port_b_out[3] ? dip_sw[7:4] : dip_sw[3:0];

endmodule

// ==== src/pcxt_ctrl_top.sv ====
// PC/XT system control top
`timescale 1ns/10ps

module pcxt_ctrl_top
	import pcxt_ctrl_pkg::*;
#(
	parameter int SPLASH_TICKS = SPLASH_TICKS_DEFAULT
) (
	input  logic         CLK_50M,
	input  logic         reset_wire,
	input  status_word_t status,
	input  logic         user_button,
	input  logic         opl2_clk,
	input  ps2_lines_t   ps2_in,
	input  logic [7:0]   port_b_out,
	output logic         splash_active,
	output logic         sys_reset,
	output logic         cpu_reset,
	output audio_en_t    audio_en,
	output ps2_lines_t   ps2_sync,
	output video_cfg_t   video_cfg,
	output logic [3:0]   port_c_low
);

	////////////////////////////////////////////////////////////
	// Reset chain
	////////////////////////////////////////////////////////////

	splash_timer #(
		.SPLASH_TICKS(SPLASH_TICKS)
	) u_splash_timer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.skip          (status[STATUS_SPLASH_SKIP_BIT]),
		.splash_active (splash_active)
	);

	reset_stretcher u_reset_stretcher (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.splash_active (splash_active),
		.host_reset    (status[STATUS_RESET_BIT]),
		.user_button   (user_button),
		.sys_reset     (sys_reset)
	);

	cpu_reset_delay u_cpu_reset_delay (
		.CLK_50M   (CLK_50M),
		.sys_reset (sys_reset),
		.cpu_reset (cpu_reset)
	);

	////////////////////////////////////////////////////////////
	// Side blocks
	////////////////////////////////////////////////////////////

	// Keyboard lines into the clock domain
	input_sync #(
		.T(ps2_lines_t)
	) u_ps2_sync (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.d          (ps2_in),
		.q          (ps2_sync)
	);

	audio_enables u_audio_enables (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.opl2_clk   (opl2_clk),
		.audio_en   (audio_en)
	);

	config_decode u_config_decode (
		.status     (status),
		.port_b_out (port_b_out),
		.video_cfg  (video_cfg),
		.port_c_low (port_c_low)
	);

endmodule

// ==== dv/pcxt_ctrl_chk.sv ====
// Reset chain and enable checks
`timescale 1ns/10ps

module pcxt_ctrl_chk
	import pcxt_ctrl_pkg::*;
(
	input logic      CLK_50M,
	input logic      reset_wire,
	input logic      splash_active,
	input logic      sys_reset,
	input logic      cpu_reset,
	input audio_en_t audio_en
);

	// CPU held whenever the system is held
	cpu_follows_sys: assert property (@(posedge CLK_50M) sys_reset |-> cpu_reset)
		else $error("cpu_reset low while sys_reset high");

	// Sample enable is a lone pulse
	cen_44100_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!(audio_en.cen_44100 && $past(audio_en.cen_44100)))
		else $error("cen_44100 high in two adjacent cycles");

	// FM enable is a lone pulse
	cen_opl2_single: assert property (@(posedge CLK_50M) disable iff (reset_wire)
		!(audio_en.cen_opl2 && $past(audio_en.cen_opl2)))
		else $error("cen_opl2 high in two adjacent cycles");

	// Only a hard reset restarts the splash
	splash_rise_on_reset: assert property (@(posedge CLK_50M)
		$rose(splash_active) |-> reset_wire)
		else $error("splash_active rose without reset_wire");

endmodule

bind pcxt_ctrl_top pcxt_ctrl_chk u_pcxt_ctrl_chk (
	.CLK_50M       (CLK_50M),
	.reset_wire    (reset_wire),
	.splash_active (splash_active),
	.sys_reset     (sys_reset),
	.cpu_reset     (cpu_reset),
	.audio_en      (audio_en)
);

// ==== dv/pcxt_ctrl_tb.sv ====
// PC/XT system control testbench
`timescale 1ns/10ps

module pcxt_ctrl_tb
	import pcxt_ctrl_pkg::*;
();

	////////////////////////////////////////////////////////////
	// Test lengths and limits
	////////////////////////////////////////////////////////////

	localparam int TB_SPLASH_TICKS = 100;
	localparam int CLK_PERIOD_NS   = 20;
	localparam int STRETCH_CYCLES  = 1 << RESET_STRETCH_W;
	// Restart requests land this far into the stretch
	localparam int RESTART_GAP     = 1000;
	localparam int RATE_CYCLES     = 200_000;
	localparam int FM_PERIODS      = 50;
	localparam int FM_MAX_PERIOD   = 20;
	localparam int PS2_ITEMS       = 16;
	localparam int CHAIN_CYCLES    = STRETCH_CYCLES + CPU_RESET_DELAY + 8;
	localparam logic [31:0] RANDOM_SEED = 32'h3c4d8c44;

	// Sum of all tests in cycles
	localparam longint TEST_CYCLES =
		(8 + SPLASH_SECONDS * TB_SPLASH_TICKS + CHAIN_CYCLES) +
		(8 + 2 * RESTART_GAP + 3 * CHAIN_CYCLES) +
		(8 + RATE_CYCLES) +
		(16 + FM_PERIODS * FM_MAX_PERIOD + 3 * PS2_ITEMS) +
		(8 + 4 * 4 * 4 * 2);
	localparam longint WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD_NS;

	logic         CLK_50M;
	logic         reset_wire;
	status_word_t status;
	logic         user_button;
	logic         opl2_clk;
	ps2_lines_t   ps2_in;
	logic [7:0]   port_b_out;
	logic         splash_active;
	logic         sys_reset;
	logic         cpu_reset;
	audio_en_t    audio_en;
	ps2_lines_t   ps2_sync;
	video_cfg_t   video_cfg;
	logic [3:0]   port_c_low;

	// Run bookkeeping
	int error_count;
	int tests_run;
	int tests_failed;
	int test_errors_start;

	pcxt_ctrl_top #(
		.SPLASH_TICKS(TB_SPLASH_TICKS)
	) u_pcxt_ctrl_top (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status        (status),
		.user_button   (user_button),
		.opl2_clk      (opl2_clk),
		.ps2_in        (ps2_in),
		.port_b_out    (port_b_out),
		.splash_active (splash_active),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.audio_en      (audio_en),
		.ps2_sync      (ps2_sync),
		.video_cfg     (video_cfg),
		.port_c_low    (port_c_low)
	);

	// 50 MHz
	always #10 CLK_50M = ~CLK_50M;

	////////////////////////////////////////////////////////////
	// Check helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_range(input string name, input int got, input int lo, input int hi);
		assert (got >= lo && got <= hi) else begin
			$display("Fail at %0t ns: %s = %0d, expected %0d to %0d", $time, name, got, lo, hi);
			error_count++;
		end
	endtask

	task automatic start_test();
		test_errors_start = error_count;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (error_count == test_errors_start) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, error_count - test_errors_start);
		end
	endtask

	// 0 splash, 1 system reset, 2 CPU reset
	function automatic logic reset_level(input int sel);
		case (sel)
			0:       return splash_active;
			1:       return sys_reset;
			default: return cpu_reset;
		endcase
	endfunction

	// Rising edges until the level is seen low
	task automatic count_until_low(input int sel, input string name, input int limit,
			output int cycles);
		cycles = 0;
		do begin
			@(posedge CLK_50M);
			cycles++;
			@(negedge CLK_50M);
		end while (reset_level(sel) && cycles < limit);
		assert (!reset_level(sel)) else begin
			$display("Timeout: %s did not fall within %0d cycles", name, limit);
			error_count++;
		end
	endtask

	task automatic apply_reset(input status_word_t st);
		@(posedge CLK_50M);
		status     <= st;
		reset_wire <= 1'b1;
		repeat (3) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	// Stretch then CPU delay, from the last request
	task automatic check_release_schedule();
		int cycles;
		count_until_low(1, "sys_reset", STRETCH_CYCLES + 16, cycles);
		check_range("sys_reset hold cycles", cycles, STRETCH_CYCLES - 2, STRETCH_CYCLES + 2);
		count_until_low(2, "cpu_reset", CPU_RESET_DELAY + 16, cycles);
		check_value("cpu_reset delay cycles", 64'(cycles), 64'(CPU_RESET_DELAY + 1));
	endtask

	// One-cycle request, 0 host bit, 1 button
	task automatic pulse_request(input int sel);
		@(posedge CLK_50M);
		if (sel == 0) begin
			status[STATUS_RESET_BIT] <= 1'b1;
		end else begin
			user_button <= 1'b1;
		end
		@(posedge CLK_50M);
		status[STATUS_RESET_BIT] <= 1'b0;
		user_button              <= 1'b0;
		@(negedge CLK_50M);
		check_value("sys_reset", 64'(sys_reset), 64'd1);
		check_value("cpu_reset", 64'(cpu_reset), 64'd1);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_splash_chain();
		int cycles;
		start_test();
		apply_reset('0);
		count_until_low(0, "splash_active", SPLASH_SECONDS * TB_SPLASH_TICKS + 16, cycles);
		check_range("splash_active hold cycles", cycles,
			SPLASH_SECONDS * TB_SPLASH_TICKS - 5, SPLASH_SECONDS * TB_SPLASH_TICKS + 5);
		check_value("sys_reset", 64'(sys_reset), 64'd1);
		check_release_schedule();
		finish_test("splash and reset chain");
	endtask

	task automatic test_skip_and_requests();
		status_word_t st;
		int           cycles;
		start_test();
		st = '0;
		st[STATUS_SPLASH_SKIP_BIT] = 1'b1;
		apply_reset(st);
		count_until_low(0, "splash_active", 4, cycles);
		check_value("splash_active release cycles", 64'(cycles), 64'd1);
		check_release_schedule();
		// Host bit then button, each from idle and again mid-stretch
		for (int sel = 0; sel < 2; sel++) begin
			pulse_request(sel);
			repeat (RESTART_GAP) @(posedge CLK_50M);
			pulse_request(sel);
			check_release_schedule();
		end
		finish_test("skip and re-request");
	endtask

	task automatic test_sample_rate();
		int pulses;
		int expected;
		start_test();
		apply_reset('0);
		pulses = 0;
		repeat (RATE_CYCLES) begin
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			if (audio_en.cen_44100) pulses++;
		end
		expected = int'((longint'(RATE_CYCLES) * SAMPLE_HZ) / CLK_HZ);
		check_range("cen_44100 pulse count", pulses, expected - 1, expected + 1);
		finish_test("sample enable rate");
	endtask

	task automatic test_fm_and_ps2();
		int          period;
		int          high_len;
		int          pulses;
		logic [31:0] rnd;
		ps2_lines_t  value;
		ps2_lines_t  prev;
		start_test();
		apply_reset('0);
		pulses = 0;
		for (int p = 0; p < FM_PERIODS; p++) begin
			period   = $urandom_range(FM_MAX_PERIOD, 6);
			high_len = period / 2;
			for (int c = 0; c < period; c++) begin
				@(posedge CLK_50M);
				opl2_clk <= (c < high_len);
				@(negedge CLK_50M);
				if (audio_en.cen_opl2) pulses++;
			end
		end
		// Drain the sync and edge stages
		repeat (8) begin
			@(posedge CLK_50M);
			opl2_clk <= 1'b0;
			@(negedge CLK_50M);
			if (audio_en.cen_opl2) pulses++;
		end
		check_range("cen_opl2 pulse count", pulses, FM_PERIODS - 1, FM_PERIODS + 1);

		// Keyboard lines, two stages of delay
		prev = '0;
		for (int i = 0; i < PS2_ITEMS; i++) begin
			rnd   = $urandom();
			value = rnd[1:0];
			@(posedge CLK_50M);
			ps2_in <= value;
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			check_value("ps2_sync", 64'(ps2_sync), 64'(prev));
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			check_value("ps2_sync", 64'(ps2_sync), 64'(value));
			prev = value;
		end
		finish_test("FM enable and PS/2 sync");
	endtask

	task automatic test_config_decode();
		status_word_t st;
		video_cfg_t   exp_cfg;
		logic [7:0]   sw;
		logic [3:0]   exp_c;
		logic [1:0]   ar;
		logic [1:0]   sc;
		start_test();
		for (int a = 0; a < 4; a++) begin
			for (int s = 0; s < 4; s++) begin
				// Bit 0 MDA, bit 1 Tandy
				for (int m = 0; m < 4; m++) begin
					for (int b = 0; b < 2; b++) begin
						ar = 2'(a);
						sc = 2'(s);
						st = '0;
						st[STATUS_AR_LSB +: 2]    = ar;
						st[STATUS_SCALE_LSB +: 2] = sc;
						st[STATUS_MDA_BIT]        = m[0];
						st[STATUS_TANDY_BIT]      = m[1];
						@(posedge CLK_50M);
						status     <= st;
						port_b_out <= {4'b0000, b[0], 3'b000};
						// Original 4:3 or custom code
						exp_cfg.arx = (a == 0) ? ar_dim_t'(AR_DEFAULT_X) : ar_dim_t'(a - 1);
						exp_cfg.ary = (a == 0) ? ar_dim_t'(AR_DEFAULT_Y) : ar_dim_t'(0);
						exp_cfg.vga_sl[1]   = (s == 3);
						exp_cfg.vga_sl[0]   = (s == 2);
						exp_cfg.scandoubler = (s != 0);
						exp_cfg.hq2x        = (s == 1);
						exp_cfg.mda_mode    = m[0];
						exp_cfg.tandy_mode  = m[1];
						sw    = m[0] ? DIP_SW_MDA : DIP_SW_CGA;
						exp_c = b[0] ? sw[7:4] : sw[3:0];
						@(negedge CLK_50M);
						check_value("video_cfg", 64'(video_cfg), 64'(exp_cfg));
						check_value("port_c_low", 64'(port_c_low), 64'(exp_c));
					end
				end
			end
		end
		finish_test("configuration decode");
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		CLK_50M      = 1'b0;
		reset_wire   = 1'b1;
		status       = '0;
		user_button  = 1'b0;
		opl2_clk     = 1'b0;
		ps2_in       = '0;
		port_b_out   = '0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(RANDOM_SEED));
		repeat (3) @(posedge CLK_50M);
		reset_wire <= 1'b0;

		test_splash_chain();
		test_skip_and_requests();
		test_sample_rate();
		test_fm_and_ps2();
		test_config_decode();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Twice the summed test length
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== sources.f ====
src/pcxt_ctrl_pkg.sv
src/input_sync.sv
src/splash_timer.sv
src/reset_stretcher.sv
src/cpu_reset_delay.sv
src/audio_enables.sv
src/config_decode.sv
src/pcxt_ctrl_top.sv
dv/pcxt_ctrl_chk.sv
dv/pcxt_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the PC/XT control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module pcxt_ctrl_tb -f sources.f -o pcxt_ctrl_sim

./obj_dir/pcxt_ctrl_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"
